/* project.f */
src/adpcma_pkg.sv
src/adpcma_slot_if.sv
src/adpcma_step_rom.sv
src/adpcma_decoder.sv
src/adpcma_channel_seq.sv
src/adpcma_mixer.sv
src/adpcma_top.sv
tests/adpcma_props.sv
tests/tb_adpcma.sv

/* Bender.yml */
package:
  name: adpcma

sources:
  - src/adpcma_pkg.sv
  - src/adpcma_slot_if.sv
  - src/adpcma_step_rom.sv
  - src/adpcma_decoder.sv
  - src/adpcma_channel_seq.sv
  - src/adpcma_mixer.sv
  - src/adpcma_top.sv
  - target: test
    files:
      - tests/adpcma_props.sv
      - tests/tb_adpcma.sv

/* tests/tb_adpcma.sv */
// module tb_adpcma: clock, reset, channel 0 stimulus, refill host, watchdog and closing report
module tb_adpcma;

    timeunit 1ns;
    timeprecision 100ps;

    // enables per test phase
    localparam int phase_en = 300;
    // four phases at four clocks per enable, plus margin, in ns
    localparam int watchdog_ns = (4 * phase_en * 4 + 200) * 40;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               cen;
    logic [5:0]         key_on;
    logic               ch_wr;
    logic [2:0]         ch_sel;
    logic [7:0]         ch_byte;
    logic [5:0]         need_data;
    logic signed [15:0] mix_out;
    logic               sample_valid;

    integer seed = 32'h8716_b037;
    // host refill control
    logic       refill_on;
    logic [7:0] refill_byte;
    int         high_en = 0;
    int         refill_errors = 0;

    adpcma_top #(
        .gain_shift (0)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cen          (cen),
        .key_on       (key_on),
        .ch_wr        (ch_wr),
        .ch_sel       (ch_sel),
        .ch_byte      (ch_byte),
        .need_data    (need_data),
        .mix_out      (mix_out),
        .sample_valid (sample_valid)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // random enable, about three clocks in four
    always @(posedge clk) begin
        cen <= ($random(seed) & 3) != 0;
        // one write per request, skip the clock after our own write
        if (refill_on && need_data[0] && !ch_wr) begin
            ch_wr <= 1'b1;
            ch_sel <= 3'd0;
            ch_byte <= refill_byte;
        end else begin
            ch_wr <= 1'b0;
        end
        // request left standing too long
        if (!refill_on || !need_data[0]) begin
            high_en <= 0;
        end else if (cen) begin
            high_en <= high_en + 1;
            if (high_en == 12) begin
                refill_errors <= refill_errors + 1;
                $display("refill request on channel 0 unanswered after 12 enables at %0t",
                         $time);
            end
        end
    end

    task automatic wait_enables(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge clk);
            if (cen) begin
                seen++;
            end
        end
    endtask

    task automatic report_and_finish(input bit timed_out);
        int assert_errors;
        assert_errors = u_dut.u_props.err_count;
        $display("error counts: %0d assertion, %0d refill, %0d timeout",
                 assert_errors, refill_errors, timed_out);
        if (timed_out || assert_errors != 0 || refill_errors != 0) begin
            $display("Some tests failed");
        end else begin
            $display("All tests passed");
        end
        $finish;
    endtask

    initial begin
        rst_n <= 1'b0;
        cen <= 1'b0;
        key_on <= '0;
        ch_wr <= 1'b0;
        ch_sel <= '0;
        ch_byte <= '0;
        refill_on <= 1'b0;
        refill_byte <= 8'h77;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        // idle, every channel off
        wait_enables(phase_en);
        // channel 0 on with positive codes
        @(posedge clk);
        key_on <= 6'b000001;
        refill_on <= 1'b1;
        wait_enables(phase_en);
        // negative codes from the next refill on
        refill_byte <= 8'hff;
        wait_enables(phase_en);
        // key off for a while, then a fresh key-on
        @(posedge clk);
        key_on <= '0;
        wait_enables(24);
        @(posedge clk);
        key_on <= 6'b000001;
        wait_enables(phase_en - 24);
        report_and_finish(1'b0);
    end

    // watchdog
    initial begin
        #(watchdog_ns);
        $display("run timed out before the last phase finished");
        report_and_finish(1'b1);
    end

endmodule

/* tests/adpcma_props.sv */
// module adpcma_props: port-level assertions on adpcma_top and the bind that attaches them
module adpcma_props (
    input logic               clk,
    input logic               rst_n,
    input logic               cen,
    input logic [5:0]         key_on,
    input logic               ch_wr,
    input logic [2:0]         ch_sel,
    input logic [7:0]         ch_byte,
    input logic [5:0]         need_data,
    input logic signed [15:0] mix_out,
    input logic               sample_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // failure count, read by the testbench at the end
    int err_count = 0;

    // last byte the host wrote to channel 0
    logic [7:0] last_byte0;
    // any key_on bit seen since reset
    logic keyed_ever;
    logic key0_q;
    // strobes since key_on[0] rose, stops at 2
    logic [1:0] rise_cnt;
    // enables since the last strobe
    logic [3:0] en_cnt;
    // enables with channel 0 on and no refill request
    logic [4:0] low_cnt;
    // mix_out at the previous strobe
    logic signed [15:0] prev_mix;
    logic steady0;
    logic pos_byte;
    logic neg_byte;

    // channel 0 alone, past its key-on clear
    assign steady0 = sample_valid && key_on == 6'b000001 && rise_cnt == 2'd2;
    // both nibbles positive or both negative
    assign pos_byte = !last_byte0[7] && !last_byte0[3];
    assign neg_byte = last_byte0[7] && last_byte0[3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_byte0 <= '0;
            keyed_ever <= 1'b0;
            key0_q <= 1'b0;
            rise_cnt <= '0;
            en_cnt <= '0;
            low_cnt <= '0;
            prev_mix <= '0;
        end else begin
            key0_q <= key_on[0];
            if (|key_on) begin
                keyed_ever <= 1'b1;
            end
            if (ch_wr && ch_sel == 3'd0) begin
                last_byte0 <= ch_byte;
            end
            // a strobe restarts the count, its own edge included
            if (sample_valid) begin
                en_cnt <= {3'b000, cen};
                prev_mix <= mix_out;
            end else if (cen && en_cnt != 4'd15) begin
                en_cnt <= en_cnt + 4'd1;
            end
            // strobe on the rise clock counts as the first one
            if (key_on[0] && !key0_q) begin
                rise_cnt <= {1'b0, sample_valid};
            end else if (sample_valid && rise_cnt != 2'd2) begin
                rise_cnt <= rise_cnt + 2'd1;
            end
            if (need_data[0] || !key_on[0]) begin
                low_cnt <= '0;
            end else if (cen && low_cnt != 5'd31) begin
                low_cnt <= low_cnt + 5'd1;
            end
        end
    end

    a_idle_silent: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid && !keyed_ever |-> mix_out == 16'sd0)
    else begin
        $error("mix_out %0d with all channels idle at %0t", mix_out, $time);
        err_count++;
    end

    // six enables per strobe, never fewer or more
    a_strobe_period: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid ? en_cnt == 4'd6 : en_cnt < 4'd6)
    else begin
        $error("strobe spacing wrong, %0d enables counted at %0t", en_cnt, $time);
        err_count++;
    end

    a_rise_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        steady0 && pos_byte |-> mix_out >= prev_mix)
    else begin
        $error("mix_out fell from %0d to %0d at %0t", prev_mix, mix_out, $time);
        err_count++;
    end

    a_fall_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        steady0 && neg_byte |-> mix_out <= prev_mix)
    else begin
        $error("mix_out rose from %0d to %0d at %0t", prev_mix, mix_out, $time);
        err_count++;
    end

    // positive byte has driven the channel to its top by the first negative write
    a_top_settled: assert property (@(posedge clk) disable iff (!rst_n)
        ch_wr && ch_sel == 3'd0 && ch_byte == 8'hff && last_byte0 == 8'h77
        |-> mix_out == 16'sh7ff8)
    else begin
        $error("mix_out %0d not settled at 32760 at %0t", mix_out, $time);
        err_count++;
    end

    a_bottom_settled: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(key_on[0]) && last_byte0 == 8'hff |-> mix_out == 16'sh8000)
    else begin
        $error("mix_out %0d not settled at -32768 at %0t", mix_out, $time);
        err_count++;
    end

    // smallest increment 2, shifted by three
    a_keyon_near_zero: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid && key_on == 6'b000001 && rise_cnt == 2'd1
        |-> mix_out <= 16'sd16 && mix_out >= -16'sd16)
    else begin
        $error("mix_out %0d after key-on, expected near zero at %0t", mix_out, $time);
        err_count++;
    end

    a_write_clears_req: assert property (@(posedge clk) disable iff (!rst_n)
        ch_wr && ch_sel == 3'd0 |=> !need_data[0])
    else begin
        $error("need_data[0] still high after a write at %0t", $time);
        err_count++;
    end

    a_req_returns: assert property (@(posedge clk) disable iff (!rst_n)
        low_cnt <= 5'd12)
    else begin
        $error("need_data[0] low for %0d enables at %0t", low_cnt, $time);
        err_count++;
    end

    // channels 1..5 never loaded, so they keep asking
    a_unused_req: assert property (@(posedge clk) disable iff (!rst_n)
        need_data[5:1] == 5'b11111)
    else begin
        $error("need_data %b dropped on an unloaded channel at %0t", need_data, $time);
        err_count++;
    end

endmodule

bind adpcma_top adpcma_props u_props (.*);

/* src/adpcma_top.sv */
// module adpcma_top: sequencer, decoder and mixer behind plain ports
module adpcma_top #(
    parameter int gain_shift = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    input  logic [5:0]         key_on,
    input  logic               ch_wr,
    input  logic [2:0]         ch_sel,
    input  logic [7:0]         ch_byte,
    output logic [5:0]         need_data,
    output logic signed [15:0] mix_out,
    output logic               sample_valid
);

    // stage I output of the decoder, current slot
    logic signed [15:0] dec_pcm;

    adpcma_slot_if u_slot_if ();

    adpcma_channel_seq u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .key_on    (key_on),
        .ch_wr     (ch_wr),
        .ch_sel    (ch_sel),
        .ch_byte   (ch_byte),
        .need_data (need_data),
        .slot_out  (u_slot_if.seq)
    );

    adpcma_decoder u_dec (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen     (cen),
        .slot_in (u_slot_if.dec),
        .pcm     (dec_pcm)
    );

    adpcma_mixer #(
        .gain_shift (gain_shift)
    ) u_mix (
        .clk          (clk),
        .rst_n        (rst_n),
        .cen          (cen),
        .slot_in      (u_slot_if.mix),
        .pcm          (dec_pcm),
        .mix_out      (mix_out),
        .sample_valid (sample_valid)
    );

endmodule

/* src/adpcma_mixer.sv */
// module adpcma_mixer: per-round channel sum, attenuation shift, 16-bit saturation, sample strobe
module adpcma_mixer #(
    parameter int gain_shift = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    adpcma_slot_if.mix         slot_in,
    input  logic signed [15:0] pcm,
    output logic signed [15:0] mix_out,
    output logic               sample_valid
);

    // six 16-bit channels need 19 bits
    localparam int acc_w = 19;
    localparam logic signed [acc_w-1:0] sat_pos = 19'sd32767;
    localparam logic signed [acc_w-1:0] sat_neg = -19'sd32768;

    logic signed [acc_w-1:0] acc;
    logic signed [acc_w-1:0] total;
    logic signed [acc_w-1:0] scaled;
    logic signed [15:0] sat_val;
    logic last_slot;

    assign last_slot = int'(slot_in.slot) == adpcma_pkg::num_ch - 1;
    assign total = acc + {{(acc_w - 16){pcm[15]}}, pcm};
    // attenuation
    assign scaled = total >>> gain_shift;

    always_comb begin
        if (scaled > sat_pos) begin
            sat_val = 16'sh7fff;
        end else if (scaled < sat_neg) begin
            sat_val = 16'sh8000;
        end else begin
            sat_val = scaled[15:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
            mix_out <= '0;
            sample_valid <= 1'b0;
        end else begin
            // one clock wide, right after the last slot is summed
            sample_valid <= cen & last_slot;
            if (cen) begin
                if (last_slot) begin
                    mix_out <= sat_val;
                    acc <= '0;
                end else begin
                    acc <= total;
                end
            end
        end
    end

endmodule

/* src/adpcma_channel_seq.sv */
// module adpcma_channel_seq: slot counter, per-channel byte and phase, key-on clear, refill requests
module adpcma_channel_seq (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,
    input  logic [5:0] key_on,
    input  logic       ch_wr,
    input  logic [2:0] ch_sel,
    input  logic [7:0] ch_byte,
    output logic [5:0] need_data,
    adpcma_slot_if.seq slot_out
);

    logic [adpcma_pkg::slot_w-1:0] slot;
    logic [7:0] hold_byte [adpcma_pkg::num_ch];
    adpcma_pkg::nib_phase_t phase [adpcma_pkg::num_ch];
    logic [adpcma_pkg::num_ch-1:0] key_q;
    logic [adpcma_pkg::num_ch-1:0] key_rise;
    logic [adpcma_pkg::num_ch-1:0] clr_pend;
    logic [7:0] cur_byte;

    // key-on edges, sampled on enables
    assign key_rise = key_on & ~key_q;

    // current slot view
    assign cur_byte = hold_byte[slot];
    assign slot_out.slot = slot;
    assign slot_out.code = (phase[slot] == adpcma_pkg::ph_high) ? cur_byte[7:4] : cur_byte[3:0];
    assign slot_out.chon = key_on[slot];
    assign slot_out.clr = clr_pend[slot] | key_rise[slot];

    // slot counter 0..num_ch-1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (cen) begin
            if (int'(slot) == adpcma_pkg::num_ch - 1) begin
                slot <= '0;
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

    // edge seen off-slot waits for its slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_q <= '0;
            clr_pend <= '0;
        end else if (cen) begin
            key_q <= key_on;
            for (int i = 0; i < adpcma_pkg::num_ch; i++) begin
                if (int'(slot) == i) begin
                    clr_pend[i] <= 1'b0;
                end else if (key_rise[i]) begin
                    clr_pend[i] <= 1'b1;
                end
            end
        end
    end

    // host write wins over the slot service
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            need_data <= '1;
            for (int i = 0; i < adpcma_pkg::num_ch; i++) begin
                hold_byte[i] <= '0;
                phase[i] <= adpcma_pkg::ph_high;
            end
        end else begin
            for (int i = 0; i < adpcma_pkg::num_ch; i++) begin
                if (ch_wr && int'(ch_sel) == i) begin
                    hold_byte[i] <= ch_byte;
                    phase[i] <= adpcma_pkg::ph_high;
                    need_data[i] <= 1'b0;
                end else if (cen && int'(slot) == i && key_on[i]) begin
                    if (phase[i] == adpcma_pkg::ph_low) begin
                        // byte used up, old one repeats unless refilled
                        phase[i] <= adpcma_pkg::ph_high;
                        need_data[i] <= 1'b1;
                    end else begin
                        phase[i] <= adpcma_pkg::ph_low;
                    end
                end
            end
        end
    end

endmodule

/* src/adpcma_decoder.sv */
// module adpcma_decoder: six-stage time-shared adpcm-a decoder with step adaptation and clamping
module adpcma_decoder (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    adpcma_slot_if.dec         slot_in,
    output logic signed [15:0] pcm
);

    typedef logic signed [adpcma_pkg::sigw-1:0] samp_t;
    typedef logic signed [adpcma_pkg::sigw:0] wide_t;
    typedef logic [adpcma_pkg::step_w-1:0] step_t;

    // limits: sign plus 12-bit magnitude
    localparam wide_t max_pos = wide_t'(2 ** (adpcma_pkg::sigw - 1) - 1);
    localparam wide_t max_neg = wide_t'(-(2 ** (adpcma_pkg::sigw - 1)));
    localparam step_t step_top = step_t'(adpcma_pkg::step_max);

    // one channel per stage, x = sample, step = step index
    samp_t x1, x2, x3, x4, x6;
    wide_t x5;
    step_t step1, step2, step3, step4, step5, step6;
    step_t step_next;
    step_t step_1p;
    logic  sign2, sign3;
    logic  chon2, chon3, chon4;
    logic [8:0]  lut_addr2;
    logic [11:0] inc3;
    samp_t inc3_ext;
    samp_t inc4;
    samp_t x1_eff;

    // cleared channel contributes zero straight away
    assign x1_eff = slot_in.clr ? samp_t'(0) : x1;
    assign pcm = 16'(x1_eff) <<< 3;

    // step adaptation from the magnitude bits
    always_comb begin
        step_next = step1;
        if (!slot_in.code[2]) begin
            step_next = (step1 == step_t'(0)) ? step_t'(0) : step1 - step_t'(1);
        end else begin
            case (slot_in.code[1:0])
                2'd0: step_next = step1 + step_t'(2);
                2'd1: step_next = step1 + step_t'(5);
                2'd2: step_next = step1 + step_t'(7);
                default: step_next = step1 + step_t'(9);
            endcase
        end
        // cap at the top of the table
        step_1p = (step_next > step_top) ? step_top : step_next;
    end

    adpcma_step_rom u_step_rom (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .addr  (lut_addr2),
        .inc   (inc3)
    );

    // rom output is unsigned magnitude
    assign inc3_ext = samp_t'({1'b0, inc3});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x1 <= '0;
            x2 <= '0;
            x3 <= '0;
            x4 <= '0;
            x5 <= '0;
            x6 <= '0;
            step1 <= '0;
            step2 <= '0;
            step3 <= '0;
            step4 <= '0;
            step5 <= '0;
            step6 <= '0;
            sign2 <= 1'b0;
            sign3 <= 1'b0;
            chon2 <= 1'b0;
            chon3 <= 1'b0;
            chon4 <= 1'b0;
            lut_addr2 <= '0;
            inc4 <= '0;
        end else if (cen) begin
            // I: new step, table address, clear
            sign2 <= slot_in.code[3];
            x2 <= x1_eff;
            step2 <= slot_in.clr ? step_t'(0) : (slot_in.chon ? step_1p : step1);
            // no increment on the clearing pass
            chon2 <= slot_in.chon & ~slot_in.clr;
            lut_addr2 <= {step1, slot_in.code[2:0]};
            // II: table lookup in flight
            sign3 <= sign2;
            x3 <= x2;
            step3 <= step2;
            chon3 <= chon2;
            // III: apply sign
            inc4 <= sign3 ? -inc3_ext : inc3_ext;
            x4 <= x3;
            step4 <= step3;
            chon4 <= chon3;
            // IV: accumulate, one bit wider
            x5 <= chon4 ? wide_t'(x4) + wide_t'(inc4) : wide_t'(x4);
            step5 <= step4;
            // V: clamp
            if (x5 > max_pos) begin
                x6 <= samp_t'(max_pos);
            end else if (x5 < max_neg) begin
                x6 <= samp_t'(max_neg);
            end else begin
                x6 <= samp_t'(x5);
            end
            step6 <= step5;
            // VI: back to stage I
            x1 <= x6;
            step1 <= step6;
        end
    end

endmodule

/* src/adpcma_step_rom.sv */
// module adpcma_step_rom: registered adpcm-a step increment table, addressed by step and magnitude
module adpcma_step_rom (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cen,
    input  logic [8:0]  addr,
    output logic [11:0] inc
);

    logic [10:0] step_size;
    logic [14:0] prod;

    // adpcm-a step sizes, index 0..48
    always_comb begin
        case (addr[8:3])
            6'd0:  step_size = 11'd16;
            6'd1:  step_size = 11'd17;
            6'd2:  step_size = 11'd19;
            6'd3:  step_size = 11'd21;
            6'd4:  step_size = 11'd23;
            6'd5:  step_size = 11'd25;
            6'd6:  step_size = 11'd28;
            6'd7:  step_size = 11'd31;
            6'd8:  step_size = 11'd34;
            6'd9:  step_size = 11'd37;
            6'd10: step_size = 11'd41;
            6'd11: step_size = 11'd45;
            6'd12: step_size = 11'd50;
            6'd13: step_size = 11'd55;
            6'd14: step_size = 11'd60;
            6'd15: step_size = 11'd66;
            6'd16: step_size = 11'd73;
            6'd17: step_size = 11'd80;
            6'd18: step_size = 11'd88;
            6'd19: step_size = 11'd97;
            6'd20: step_size = 11'd107;
            6'd21: step_size = 11'd118;
            6'd22: step_size = 11'd130;
            6'd23: step_size = 11'd143;
            6'd24: step_size = 11'd157;
            6'd25: step_size = 11'd173;
            6'd26: step_size = 11'd190;
            6'd27: step_size = 11'd209;
            6'd28: step_size = 11'd230;
            6'd29: step_size = 11'd253;
            6'd30: step_size = 11'd279;
            6'd31: step_size = 11'd307;
            6'd32: step_size = 11'd337;
            6'd33: step_size = 11'd371;
            6'd34: step_size = 11'd408;
            6'd35: step_size = 11'd449;
            6'd36: step_size = 11'd494;
            6'd37: step_size = 11'd544;
            6'd38: step_size = 11'd598;
            6'd39: step_size = 11'd658;
            6'd40: step_size = 11'd724;
            6'd41: step_size = 11'd796;
            6'd42: step_size = 11'd876;
            6'd43: step_size = 11'd963;
            6'd44: step_size = 11'd1060;
            6'd45: step_size = 11'd1166;
            6'd46: step_size = 11'd1282;
            6'd47: step_size = 11'd1411;
            6'd48: step_size = 11'd1552;
            default: step_size = 11'd0;
        endcase
    end

    // increment = (2m+1) * step / 8
    // largest entry 15 * 1552 / 8 = 2910, fits 12 bits
    assign prod = 15'(step_size) * 15'({addr[2:0], 1'b1});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inc <= '0;
        end else if (cen) begin
            inc <= prod[14:3];
        end
    end

endmodule

/* src/adpcma_slot_if.sv */
// interface adpcma_slot_if: current slot, code, key state and clear, with seq/dec/mix modports
interface adpcma_slot_if;

    // slot number being served this enable
    logic [adpcma_pkg::slot_w-1:0] slot;
    // 4-bit adpcm code of that slot, bit 3 is the sign
    logic [3:0] code;
    // channel keyed on
    logic chon;
    // zero the channel state on this pass
    logic clr;

    modport seq (output slot, output code, output chon, output clr);
    modport dec (input code, input chon, input clr);
    modport mix (input slot);

endinterface

/* src/adpcma_pkg.sv */
// package adpcma_pkg: channel count, sample and step widths, step limit, nibble phase enum
package adpcma_pkg;

    // channel slots, also the decoder pipeline depth
    localparam int num_ch = 6;

    // internal sample width
    // 12-bit audio plus one bit of overflow headroom
    localparam int sigw = 13;

    // step index range 0..step_max
    localparam int step_max = 48;
    localparam int step_w = 6;

    // slot number width, enough for num_ch
    localparam int slot_w = 3;

    // which half of the held byte is played next
    typedef enum logic [0:0] {
        ph_high = 1'b0,
        ph_low  = 1'b1
    } nib_phase_t;

endpackage
